//--- hw/axi_mem_pkg.sv
package axi_mem_pkg;

    // ------------------------------------------------------------------------
    // Vector types shared by the engines, the arbiter and the RAM.
    // ------------------------------------------------------------------------
    typedef logic [31:0] addr_t;  // Byte address.
    typedef logic [31:0] data_t;  // One beat, one RAM word.
    typedef logic [3:0]  strb_t;  // Byte strobes.
    typedef logic [7:0]  len_t;   // Beats minus one.
    typedef logic [1:0]  burst_t; // Burst type.
    typedef logic [1:0]  resp_t;  // Response code.

    // ------------------------------------------------------------------------
    // Burst codes.
    // ------------------------------------------------------------------------

    // Address stays put for every beat.
    localparam burst_t BURST_FIXED = 2'd0;

    // Address steps by one word per beat.
    // Any code other than FIXED steps the same way.
    localparam burst_t BURST_INCR  = 2'd1;

    // ------------------------------------------------------------------------
    // Response codes.
    // ------------------------------------------------------------------------
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2; // Beat outside the memory.

endpackage

//--- hw/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
    parameter int MEM_AW = 8
) (
    input  logic                  clk,
    input  logic                  i_en,
    input  logic                  i_we,
    input  logic [MEM_AW-1:0]     i_idx,
    input  axi_mem_pkg::data_t    i_wdata,
    input  axi_mem_pkg::strb_t    i_wstrb,
    output axi_mem_pkg::data_t    o_rdata
);

    localparam int DEPTH = 2 ** MEM_AW;

    axi_mem_pkg::data_t mem [DEPTH];

    // ------------------------------------------------------------------------
    // Single port. Read data is registered, one cycle latency.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                for (int i = 0; i < 4; i++) begin
                    if (i_wstrb[i]) begin
                        mem[i_idx][8*i +: 8] <= i_wdata[8*i +: 8]; // Strobed byte only.
                    end
                end
            end else begin
                o_rdata <= mem[i_idx];
            end
        end
    end

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int MEM_AW = 8
) (
    input  logic                  clk,
    input  logic                  AR_VALID,

    // Engine A.
    input  logic                  i_a_req,
    input  logic                  i_a_we,
    input  logic [MEM_AW-1:0]     i_a_widx,
    input  axi_mem_pkg::data_t    i_a_wdata,
    input  axi_mem_pkg::strb_t    i_a_wstrb,

    // Engine B.
    input  logic                  i_b_req,
    input  logic                  i_b_we,
    input  logic [MEM_AW-1:0]     i_b_widx,
    input  axi_mem_pkg::data_t    i_b_wdata,
    input  axi_mem_pkg::strb_t    i_b_wstrb,

    output logic                  o_a_gnt,
    output logic                  o_b_gnt,

    // RAM side.
    output logic                  o_en,
    output logic                  o_we,
    output logic [MEM_AW-1:0]     o_idx,
    output axi_mem_pkg::data_t    o_wdata,
    output axi_mem_pkg::strb_t    o_wstrb
);

    logic last_b_q; // Set when B won the last grant.

    // A tie goes to whoever did not win last.
    assign o_a_gnt = i_a_req & (~i_b_req | last_b_q);
    assign o_b_gnt = i_b_req & (~i_a_req | ~last_b_q);

    always_ff @(posedge clk or posedge AR_VALID) begin
        if (AR_VALID) begin
            last_b_q <= 1'b1; // A takes the first tie.
        end else if (o_a_gnt) begin
            last_b_q <= 1'b0;
        end else if (o_b_gnt) begin
            last_b_q <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Winner's fields onto the RAM.
    // ------------------------------------------------------------------------
    assign o_en    = o_a_gnt | o_b_gnt;
    assign o_we    = o_b_gnt ? i_b_we    : (o_a_gnt & i_a_we);
    assign o_idx   = o_b_gnt ? i_b_widx  : i_a_widx;
    assign o_wdata = o_b_gnt ? i_b_wdata : i_a_wdata;
    assign o_wstrb = o_b_gnt ? i_b_wstrb : i_a_wstrb;

endmodule

//--- hw/axi_burst_slave.sv
`timescale 1ns/1ps

module axi_burst_slave #(
    parameter int MEM_AW = 8
) (
    input  logic                  clk,
    input  logic                  AR_VALID,

    // Read address channel.
    input  logic                  i_ar_valid,
    output logic                  o_ar_ready,
    input  axi_mem_pkg::addr_t    i_ar_addr,
    input  axi_mem_pkg::len_t     i_ar_len,
    input  axi_mem_pkg::burst_t   i_ar_burst,

    // Read data channel.
    output logic                  o_r_valid,
    input  logic                  i_r_ready,
    output axi_mem_pkg::data_t    o_r_data,
    output axi_mem_pkg::resp_t    o_r_resp,
    output logic                  o_r_last,

    // Write address channel.
    input  logic                  i_aw_valid,
    output logic                  o_aw_ready,
    input  axi_mem_pkg::addr_t    i_aw_addr,
    input  axi_mem_pkg::len_t     i_aw_len,
    input  axi_mem_pkg::burst_t   i_aw_burst,

    // Write data channel.
    input  logic                  i_w_valid,
    output logic                  o_w_ready,
    input  axi_mem_pkg::data_t    i_w_data,
    input  axi_mem_pkg::strb_t    i_w_strb,
    input  logic                  i_w_last,

    // Write response channel.
    output logic                  o_b_valid,
    input  logic                  i_b_ready,
    output axi_mem_pkg::resp_t    o_b_resp,

    // Memory request toward the arbiter.
    output logic                  o_req,
    output logic                  o_we,
    output logic [MEM_AW-1:0]     o_widx,
    output axi_mem_pkg::data_t    o_wdata,
    output axi_mem_pkg::strb_t    o_wstrb,
    input  logic                  i_gnt,
    input  axi_mem_pkg::data_t    i_rdata
);

    typedef enum logic [2:0] {
        IDLE,
        RD_REQ,
        RD_WAIT,
        RD_DATA,
        WR_DATA,
        WR_RESP
    } state_t;

    // ------------------------------------------------------------------------
    // Internal signals.
    // ------------------------------------------------------------------------
    state_t              state_q;
    state_t              state_d;

    axi_mem_pkg::addr_t  addr_q;    // Current beat address.
    axi_mem_pkg::addr_t  next_addr;
    axi_mem_pkg::len_t   len_q;
    axi_mem_pkg::burst_t burst_q;
    axi_mem_pkg::len_t   beat_q;    // Read beats already sent.
    axi_mem_pkg::data_t  rdata_q;

    logic                in_range;
    logic                rd_err_q;  // Current read beat is out of range.
    logic                wr_err_q;  // Sticky for the whole write burst.

    logic                ar_hs;
    logic                aw_hs;
    logic                r_hs;
    logic                w_hs;

    // Every address bit above the word index must be clear.
    assign in_range  = (addr_q >> (MEM_AW + 2)) == '0;
    assign next_addr = (burst_q == axi_mem_pkg::BURST_FIXED) ? addr_q : addr_q + 32'd4;

    assign ar_hs = i_ar_valid & o_ar_ready;
    assign aw_hs = i_aw_valid & o_aw_ready;
    assign r_hs  = o_r_valid  & i_r_ready;
    assign w_hs  = i_w_valid  & o_w_ready;

    // ------------------------------------------------------------------------
    // Channel outputs.
    // ------------------------------------------------------------------------
    assign o_ar_ready = (state_q == IDLE);
    assign o_aw_ready = (state_q == IDLE) & ~i_ar_valid; // Read wins a tie.

    assign o_r_valid = (state_q == RD_DATA);
    assign o_r_data  = rdata_q;
    assign o_r_resp  = rd_err_q ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
    assign o_r_last  = (state_q == RD_DATA) && (beat_q == len_q);

    // A beat past the end is swallowed without touching the RAM.
    assign o_w_ready = (state_q == WR_DATA) & (in_range ? i_gnt : 1'b1);

    assign o_b_valid = (state_q == WR_RESP);
    assign o_b_resp  = wr_err_q ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;

    // Memory request. Held until granted.
    assign o_req   = in_range & ((state_q == RD_REQ) | ((state_q == WR_DATA) & i_w_valid));
    assign o_we    = (state_q == WR_DATA);
    assign o_widx  = addr_q[MEM_AW+1:2];
    assign o_wdata = i_w_data;
    assign o_wstrb = i_w_strb;

    // ------------------------------------------------------------------------
    // FSM.
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;

        case (state_q)
            IDLE: begin
                if (ar_hs) begin
                    state_d = RD_REQ;
                end else if (aw_hs) begin
                    state_d = WR_DATA;
                end
            end

            RD_REQ: begin
                if (!in_range) begin
                    state_d = RD_DATA; // Nothing to fetch.
                end else if (i_gnt) begin
                    state_d = RD_WAIT;
                end
            end

            RD_WAIT: state_d = RD_DATA;

            RD_DATA: begin
                if (r_hs) begin
                    state_d = o_r_last ? IDLE : RD_REQ;
                end
            end

            WR_DATA: begin
                if (w_hs && i_w_last) begin
                    state_d = WR_RESP;
                end
            end

            WR_RESP: begin
                if (i_b_ready) begin
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge AR_VALID) begin
        if (AR_VALID) begin
            state_q  <= IDLE;
            beat_q   <= '0;
            rd_err_q <= 1'b0;
            wr_err_q <= 1'b0;
        end else begin
            state_q <= state_d;

            if (ar_hs) begin
                beat_q <= '0;
            end else if (r_hs) begin
                beat_q <= beat_q + 8'd1;
            end

            if (state_q == RD_REQ) begin
                rd_err_q <= ~in_range;
            end

            if (aw_hs) begin
                wr_err_q <= 1'b0;
            end else if (w_hs && !in_range) begin
                wr_err_q <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Burst payload.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q  <= i_ar_addr;
            len_q   <= i_ar_len;
            burst_q <= i_ar_burst;
        end else if (aw_hs) begin
            addr_q  <= i_aw_addr;
            len_q   <= i_aw_len;
            burst_q <= i_aw_burst;
        end else if (r_hs || w_hs) begin
            addr_q  <= next_addr; // Step after each beat.
        end
    end

    // RAM word lands one cycle after the grant.
    always_ff @(posedge clk) begin
        if (state_q == RD_WAIT) begin
            rdata_q <= i_rdata;
        end else if (state_q == RD_REQ && !in_range) begin
            rdata_q <= '0;
        end
    end

endmodule

//--- hw/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top #(
    parameter int MEM_AW = 8
) (
    input  logic                  clk,
    input  logic                  AR_VALID,

    // ------------------------------------------------------------------------
    // Port A.
    // ------------------------------------------------------------------------
    input  logic                  i_a_ar_valid,
    output logic                  o_a_ar_ready,
    input  axi_mem_pkg::addr_t    i_a_ar_addr,
    input  axi_mem_pkg::len_t     i_a_ar_len,
    input  axi_mem_pkg::burst_t   i_a_ar_burst,
    output logic                  o_a_r_valid,
    input  logic                  i_a_r_ready,
    output axi_mem_pkg::data_t    o_a_r_data,
    output axi_mem_pkg::resp_t    o_a_r_resp,
    output logic                  o_a_r_last,
    input  logic                  i_a_aw_valid,
    output logic                  o_a_aw_ready,
    input  axi_mem_pkg::addr_t    i_a_aw_addr,
    input  axi_mem_pkg::len_t     i_a_aw_len,
    input  axi_mem_pkg::burst_t   i_a_aw_burst,
    input  logic                  i_a_w_valid,
    output logic                  o_a_w_ready,
    input  axi_mem_pkg::data_t    i_a_w_data,
    input  axi_mem_pkg::strb_t    i_a_w_strb,
    input  logic                  i_a_w_last,
    output logic                  o_a_b_valid,
    input  logic                  i_a_b_ready,
    output axi_mem_pkg::resp_t    o_a_b_resp,

    // ------------------------------------------------------------------------
    // Port B.
    // ------------------------------------------------------------------------
    input  logic                  i_b_ar_valid,
    output logic                  o_b_ar_ready,
    input  axi_mem_pkg::addr_t    i_b_ar_addr,
    input  axi_mem_pkg::len_t     i_b_ar_len,
    input  axi_mem_pkg::burst_t   i_b_ar_burst,
    output logic                  o_b_r_valid,
    input  logic                  i_b_r_ready,
    output axi_mem_pkg::data_t    o_b_r_data,
    output axi_mem_pkg::resp_t    o_b_r_resp,
    output logic                  o_b_r_last,
    input  logic                  i_b_aw_valid,
    output logic                  o_b_aw_ready,
    input  axi_mem_pkg::addr_t    i_b_aw_addr,
    input  axi_mem_pkg::len_t     i_b_aw_len,
    input  axi_mem_pkg::burst_t   i_b_aw_burst,
    input  logic                  i_b_w_valid,
    output logic                  o_b_w_ready,
    input  axi_mem_pkg::data_t    i_b_w_data,
    input  axi_mem_pkg::strb_t    i_b_w_strb,
    input  logic                  i_b_w_last,
    output logic                  o_b_b_valid,
    input  logic                  i_b_b_ready,
    output axi_mem_pkg::resp_t    o_b_b_resp
);

    // Engine requests.
    logic                a_req;
    logic                a_we;
    logic [MEM_AW-1:0]   a_widx;
    axi_mem_pkg::data_t  a_wdata;
    axi_mem_pkg::strb_t  a_wstrb;
    logic                a_gnt;
    logic                b_req;
    logic                b_we;
    logic [MEM_AW-1:0]   b_widx;
    axi_mem_pkg::data_t  b_wdata;
    axi_mem_pkg::strb_t  b_wstrb;
    logic                b_gnt;

    // RAM port.
    logic                ram_en;
    logic                ram_we;
    logic [MEM_AW-1:0]   ram_idx;
    axi_mem_pkg::data_t  ram_wdata;
    axi_mem_pkg::strb_t  ram_wstrb;
    axi_mem_pkg::data_t  ram_rdata;   // Seen by both engines.

    axi_burst_slave #(.MEM_AW(MEM_AW)) slv_a (
        .clk        (clk),          .AR_VALID   (AR_VALID),
        .i_ar_valid (i_a_ar_valid), .o_ar_ready (o_a_ar_ready),
        .i_ar_addr  (i_a_ar_addr),  .i_ar_len   (i_a_ar_len),   .i_ar_burst (i_a_ar_burst),
        .o_r_valid  (o_a_r_valid),  .i_r_ready  (i_a_r_ready),
        .o_r_data   (o_a_r_data),   .o_r_resp   (o_a_r_resp),   .o_r_last   (o_a_r_last),
        .i_aw_valid (i_a_aw_valid), .o_aw_ready (o_a_aw_ready),
        .i_aw_addr  (i_a_aw_addr),  .i_aw_len   (i_a_aw_len),   .i_aw_burst (i_a_aw_burst),
        .i_w_valid  (i_a_w_valid),  .o_w_ready  (o_a_w_ready),
        .i_w_data   (i_a_w_data),   .i_w_strb   (i_a_w_strb),   .i_w_last   (i_a_w_last),
        .o_b_valid  (o_a_b_valid),  .i_b_ready  (i_a_b_ready),  .o_b_resp   (o_a_b_resp),
        .o_req      (a_req),        .o_we       (a_we),         .o_widx     (a_widx),
        .o_wdata    (a_wdata),      .o_wstrb    (a_wstrb),
        .i_gnt      (a_gnt),        .i_rdata    (ram_rdata)
    );

    axi_burst_slave #(.MEM_AW(MEM_AW)) slv_b (
        .clk        (clk),          .AR_VALID   (AR_VALID),
        .i_ar_valid (i_b_ar_valid), .o_ar_ready (o_b_ar_ready),
        .i_ar_addr  (i_b_ar_addr),  .i_ar_len   (i_b_ar_len),   .i_ar_burst (i_b_ar_burst),
        .o_r_valid  (o_b_r_valid),  .i_r_ready  (i_b_r_ready),
        .o_r_data   (o_b_r_data),   .o_r_resp   (o_b_r_resp),   .o_r_last   (o_b_r_last),
        .i_aw_valid (i_b_aw_valid), .o_aw_ready (o_b_aw_ready),
        .i_aw_addr  (i_b_aw_addr),  .i_aw_len   (i_b_aw_len),   .i_aw_burst (i_b_aw_burst),
        .i_w_valid  (i_b_w_valid),  .o_w_ready  (o_b_w_ready),
        .i_w_data   (i_b_w_data),   .i_w_strb   (i_b_w_strb),   .i_w_last   (i_b_w_last),
        .o_b_valid  (o_b_b_valid),  .i_b_ready  (i_b_b_ready),  .o_b_resp   (o_b_b_resp),
        .o_req      (b_req),        .o_we       (b_we),         .o_widx     (b_widx),
        .o_wdata    (b_wdata),      .o_wstrb    (b_wstrb),
        .i_gnt      (b_gnt),        .i_rdata    (ram_rdata)
    );

    mem_arbiter #(.MEM_AW(MEM_AW)) arb0 (
        .clk       (clk),       .AR_VALID  (AR_VALID),
        .i_a_req   (a_req),     .i_a_we    (a_we),      .i_a_widx  (a_widx),
        .i_a_wdata (a_wdata),   .i_a_wstrb (a_wstrb),
        .i_b_req   (b_req),     .i_b_we    (b_we),      .i_b_widx  (b_widx),
        .i_b_wdata (b_wdata),   .i_b_wstrb (b_wstrb),
        .o_a_gnt   (a_gnt),     .o_b_gnt   (b_gnt),
        .o_en      (ram_en),    .o_we      (ram_we),    .o_idx     (ram_idx),
        .o_wdata   (ram_wdata), .o_wstrb   (ram_wstrb)
    );

    word_ram #(.MEM_AW(MEM_AW)) ram0 (
        .clk     (clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_idx   (ram_idx),
        .i_wdata (ram_wdata),
        .i_wstrb (ram_wstrb),
        .o_rdata (ram_rdata)
    );

endmodule

//--- sim/axi_mem_tb.sv
`timescale 1ns/1ps

module axi_mem_tb;

    localparam int MEM_AW         = 8;
    localparam int WORDS          = 2 ** MEM_AW;
    localparam int TIMEOUT_CYCLES = 20000; // About ten times the cycles the tests need.

    logic clk;
    logic AR_VALID;
    logic bp_on;      // Random R and B back-pressure.
    int   cycles = 0;

    // ------------------------------------------------------------------------
    // Port signals. Index 0 is port A, index 1 is port B.
    // ------------------------------------------------------------------------
    logic                ar_valid [2], ar_ready [2];
    axi_mem_pkg::addr_t  ar_addr  [2], aw_addr  [2];
    axi_mem_pkg::len_t   ar_len   [2], aw_len   [2];
    axi_mem_pkg::burst_t ar_burst [2], aw_burst [2];
    logic                r_valid  [2], r_ready  [2], r_last [2];
    axi_mem_pkg::data_t  r_data   [2], w_data   [2];
    axi_mem_pkg::resp_t  r_resp   [2], b_resp   [2];
    logic                aw_valid [2], aw_ready [2];
    logic                w_valid  [2], w_ready  [2], w_last [2];
    axi_mem_pkg::strb_t  w_strb   [2];
    logic                b_valid  [2], b_ready  [2];

    axi_mem_pkg::data_t  model [WORDS]; // Expected RAM contents.

    axi_mem_top #(.MEM_AW(MEM_AW)) dut0 (
        .clk          (clk),         .AR_VALID     (AR_VALID),
        .i_a_ar_valid (ar_valid[0]), .o_a_ar_ready (ar_ready[0]), .i_a_ar_addr  (ar_addr[0]),
        .i_a_ar_len   (ar_len[0]),   .i_a_ar_burst (ar_burst[0]),
        .o_a_r_valid  (r_valid[0]),  .i_a_r_ready  (r_ready[0]),  .o_a_r_data   (r_data[0]),
        .o_a_r_resp   (r_resp[0]),   .o_a_r_last   (r_last[0]),
        .i_a_aw_valid (aw_valid[0]), .o_a_aw_ready (aw_ready[0]), .i_a_aw_addr  (aw_addr[0]),
        .i_a_aw_len   (aw_len[0]),   .i_a_aw_burst (aw_burst[0]),
        .i_a_w_valid  (w_valid[0]),  .o_a_w_ready  (w_ready[0]),  .i_a_w_data   (w_data[0]),
        .i_a_w_strb   (w_strb[0]),   .i_a_w_last   (w_last[0]),
        .o_a_b_valid  (b_valid[0]),  .i_a_b_ready  (b_ready[0]),  .o_a_b_resp   (b_resp[0]),
        .i_b_ar_valid (ar_valid[1]), .o_b_ar_ready (ar_ready[1]), .i_b_ar_addr  (ar_addr[1]),
        .i_b_ar_len   (ar_len[1]),   .i_b_ar_burst (ar_burst[1]),
        .o_b_r_valid  (r_valid[1]),  .i_b_r_ready  (r_ready[1]),  .o_b_r_data   (r_data[1]),
        .o_b_r_resp   (r_resp[1]),   .o_b_r_last   (r_last[1]),
        .i_b_aw_valid (aw_valid[1]), .o_b_aw_ready (aw_ready[1]), .i_b_aw_addr  (aw_addr[1]),
        .i_b_aw_len   (aw_len[1]),   .i_b_aw_burst (aw_burst[1]),
        .i_b_w_valid  (w_valid[1]),  .o_b_w_ready  (w_ready[1]),  .i_b_w_data   (w_data[1]),
        .i_b_w_strb   (w_strb[1]),   .i_b_w_last   (w_last[1]),
        .o_b_b_valid  (b_valid[1]),  .i_b_b_ready  (b_ready[1]),  .o_b_b_resp   (b_resp[1])
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            fail_run("Timeout: the bursts did not complete within the cycle limit.");
        end
    end

    // ------------------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic report_mismatch(input int p, input string sig,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %0t: o_%s_%s expected %h, actual %h",
                 $time, p ? "b" : "a", sig, exp, act);
        fail_run("A DUT output did not match its expected value.");
    endtask

    // Byte address inside the word array.
    function automatic bit in_mem(input axi_mem_pkg::addr_t addr);
        return addr < 32'(4 * WORDS);
    endfunction

    function automatic axi_mem_pkg::data_t merge_bytes(input axi_mem_pkg::data_t old_word,
                                                        input axi_mem_pkg::data_t new_word,
                                                        input axi_mem_pkg::strb_t strb);
        axi_mem_pkg::data_t word;
        int                 i;
        word = old_word;
        for (i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = new_word[8*i +: 8]; // Only strobed lanes change.
            end
        end
        return word;
    endfunction

    // High about two cycles in three under back-pressure.
    function automatic logic ready_pattern();
        return bp_on ? logic'(($urandom % 3) != 0) : 1'b1;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_idle(input bit readies);
        int p;
        for (p = 0; p < 2; p++) begin
            assert (!r_valid[p]) else report_mismatch(p, "r_valid", 32'd0, 32'(r_valid[p]));
            assert (!b_valid[p]) else report_mismatch(p, "b_valid", 32'd0, 32'(b_valid[p]));
            if (readies) begin
                assert (ar_ready[p])
                    else report_mismatch(p, "ar_ready", 32'd1, 32'(ar_ready[p]));
                assert (aw_ready[p])
                    else report_mismatch(p, "aw_ready", 32'd1, 32'(aw_ready[p]));
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Burst drivers. Each runs on its own port.
    // ------------------------------------------------------------------------
    task automatic write_burst(input int p, input axi_mem_pkg::addr_t addr,
                               input axi_mem_pkg::len_t len, input axi_mem_pkg::burst_t burst,
                               input bit full);
        axi_mem_pkg::addr_t a;
        axi_mem_pkg::resp_t exp_resp;
        int                 beat;
        logic               done;
        a           = addr;
        exp_resp    = axi_mem_pkg::RESP_OKAY;
        done        = 1'b0;
        aw_valid[p] = 1'b1;
        aw_addr[p]  = addr;
        aw_len[p]   = len;
        aw_burst[p] = burst;
        do begin
            @(negedge clk);
        end while (!aw_ready[p]);
        next_cycle();
        aw_valid[p] = 1'b0;
        for (beat = 0; beat <= int'(len); beat++) begin
            w_valid[p] = 1'b1;
            w_data[p]  = $urandom;
            w_strb[p]  = full ? 4'hf : axi_mem_pkg::strb_t'($urandom);
            w_last[p]  = (beat == int'(len));
            do begin
                @(negedge clk);
            end while (!w_ready[p]);
            next_cycle();
            if (in_mem(a)) begin
                model[a[MEM_AW+1:2]] = merge_bytes(model[a[MEM_AW+1:2]], w_data[p], w_strb[p]);
            end else begin
                exp_resp = axi_mem_pkg::RESP_SLVERR;
            end
            if (burst != axi_mem_pkg::BURST_FIXED) begin
                a = a + 32'd4;
            end
        end
        w_valid[p] = 1'b0;
        w_last[p]  = 1'b0;
        while (!done) begin
            b_ready[p] = ready_pattern();
            @(negedge clk);
            if (b_valid[p] && b_ready[p]) begin
                assert (b_resp[p] == exp_resp)
                    else report_mismatch(p, "b_resp", 32'(exp_resp), 32'(b_resp[p]));
                done = 1'b1;
            end
            next_cycle();
        end
        b_ready[p] = 1'b0;
    endtask

    task automatic read_burst(input int p, input axi_mem_pkg::addr_t addr,
                              input axi_mem_pkg::len_t len, input axi_mem_pkg::burst_t burst);
        axi_mem_pkg::addr_t a;
        axi_mem_pkg::data_t exp_data;
        axi_mem_pkg::resp_t exp_resp;
        int                 beat;
        a           = addr;
        beat        = 0;
        ar_valid[p] = 1'b1;
        ar_addr[p]  = addr;
        ar_len[p]   = len;
        ar_burst[p] = burst;
        do begin
            @(negedge clk);
        end while (!ar_ready[p]);
        next_cycle();
        ar_valid[p] = 1'b0;
        while (beat <= int'(len)) begin
            r_ready[p] = ready_pattern();
            @(negedge clk);
            if (r_valid[p] && r_ready[p]) begin
                exp_data = in_mem(a) ? model[a[MEM_AW+1:2]] : '0;
                exp_resp = in_mem(a) ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
                assert (r_data[p] == exp_data)
                    else report_mismatch(p, "r_data", exp_data, r_data[p]);
                assert (r_resp[p] == exp_resp)
                    else report_mismatch(p, "r_resp", 32'(exp_resp), 32'(r_resp[p]));
                assert (r_last[p] == (beat == int'(len)))
                    else report_mismatch(p, "r_last", 32'(beat == int'(len)), 32'(r_last[p]));
                if (burst != axi_mem_pkg::BURST_FIXED) begin
                    a = a + 32'd4;
                end
                beat++;
            end
            next_cycle();
        end
        r_ready[p] = 1'b0;
    endtask

    // Write then read back, inside one half of the memory per port.
    task automatic random_traffic(input int p, input int bursts);
        axi_mem_pkg::len_t   len;
        axi_mem_pkg::burst_t burst;
        int                  word;
        repeat (bursts) begin
            len   = axi_mem_pkg::len_t'($urandom % 8);
            burst = axi_mem_pkg::burst_t'($urandom % 4); // Codes 2 and 3 step like INCR.
            word  = p * (WORDS / 2) + int'($urandom % (WORDS / 2 - 8));
            write_burst(p, 32'(word * 4), len, burst, 1'b1);
            read_burst(p, 32'(word * 4), len, burst);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence.
    // ------------------------------------------------------------------------
    initial begin
        int port;
        void'($urandom(72));
        clk      = 1'b0;
        AR_VALID = 1'b1;
        bp_on    = 1'b0;
        for (port = 0; port < 2; port++) begin
            ar_valid[port] = 1'b0;
            ar_addr[port]  = '0;
            ar_len[port]   = '0;
            ar_burst[port] = '0;
            r_ready[port]  = 1'b0;
            aw_valid[port] = 1'b0;
            aw_addr[port]  = '0;
            aw_len[port]   = '0;
            aw_burst[port] = '0;
            w_valid[port]  = 1'b0;
            w_data[port]   = '0;
            w_strb[port]   = '0;
            w_last[port]   = 1'b0;
            b_ready[port]  = 1'b0;
        end

        repeat (16) begin
            next_cycle();
            check_idle(1'b0);
        end
        AR_VALID = 1'b0;
        @(negedge clk);
        check_idle(1'b1);  // Both address channels open.
        next_cycle();

        write_burst(0, 32'h0, 8'd7, axi_mem_pkg::BURST_INCR, 1'b1);
        read_burst(0, 32'h0, 8'd7, axi_mem_pkg::BURST_INCR);

        // Partial strobes over known words.
        write_burst(0, 32'h40, 8'd3, axi_mem_pkg::BURST_INCR, 1'b1);
        write_burst(0, 32'h40, 8'd3, axi_mem_pkg::BURST_INCR, 1'b0);
        read_burst(0, 32'h40, 8'd3, axi_mem_pkg::BURST_INCR);

        // FIXED beats pile onto one word.
        write_burst(1, 32'h80, 8'd0, axi_mem_pkg::BURST_INCR, 1'b1);
        write_burst(1, 32'h80, 8'd5, axi_mem_pkg::BURST_FIXED, 1'b0);
        read_burst(1, 32'h80, 8'd3, axi_mem_pkg::BURST_FIXED);

        bp_on = 1'b1;
        fork
            random_traffic(0, 12);
            random_traffic(1, 12);
        join
        bp_on = 1'b0;

        // Bursts that cross or start past the end of the memory.
        write_burst(1, 32'h3F8, 8'd3, axi_mem_pkg::BURST_INCR, 1'b1);
        read_burst(1, 32'h3F8, 8'd3, axi_mem_pkg::BURST_INCR);
        write_burst(1, 32'h400, 8'd1, axi_mem_pkg::BURST_INCR, 1'b1);
        read_burst(1, 32'h1000, 8'd2, axi_mem_pkg::BURST_INCR);
        read_burst(0, 32'h0, 8'd7, axi_mem_pkg::BURST_INCR); // Low words not aliased.

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- axi_mem.f
hw/axi_mem_pkg.sv
hw/word_ram.sv
hw/mem_arbiter.sv
hw/axi_burst_slave.sv
hw/axi_mem_top.sv
sim/axi_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module axi_mem_tb -f axi_mem.f -o axi_mem_sim

out=$(./obj_dir/axi_mem_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
